// File: Bender.yml
package:
  name: axil_mem_sys

sources:
  - axil_pkg.sv
  - axil_ram.sv
  - axil_cmd_fsm.sv
  - axil_txn_counter.sv
  - axil_mem_sys.sv
  - target: test
    files:
      - tb_axil_mem_sys.sv

// File: axil_cmd_fsm.sv
/* axil_cmd_fsm: turns single host command strobes into one AXI4-Lite
   transaction each and returns a one-cycle host response */
`timescale 1ns/1ps

module axil_cmd_fsm
   import axil_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   // host side
   input  logic       cmd_valid,
   input  host_cmd_t  cmd,
   output logic       busy,
   output logic       rsp_valid,
   output host_rsp_t  rsp,

   // AXI4-Lite master side
   output logic       awvalid,
   input  logic       awready,
   output axil_aw_t   aw,
   output logic       wvalid,
   input  logic       wready,
   output axil_w_t    w,
   input  logic       bvalid,
   output logic       bready,
   input  axil_resp_e bresp,
   output logic       arvalid,
   input  logic       arready,
   output axil_ar_t   ar,
   input  logic       rvalid,
   output logic       rready,
   input  axil_r_t    r
);

   cmd_state_e state;
   cmd_state_e state_next;
   host_cmd_t  cmd_q;
   logic       accept;
   logic       acc_wr;
   logic       acc_rd;

   // transaction in flight only in the two bus states
   assign busy = (state == ST_WRITE) || (state == ST_READ);

   // ST_DONE also takes a command, so back-to-back strobes land in T+3
   assign accept = cmd_valid && !busy;
   assign acc_wr = accept && (cmd.op == OP_WRITE);
   assign acc_rd = accept && (cmd.op == OP_READ);

   assign rsp_valid = (state == ST_DONE);

   // responses are always taken
   assign bready = 1'b1;
   assign rready = 1'b1;

   // request payloads from the latched command, prot tied off
   assign aw = '{addr: cmd_q.addr, prot: 3'b000};
   assign w  = '{data: cmd_q.data, strb: cmd_q.strb};
   assign ar = '{addr: cmd_q.addr, prot: 3'b000};

   // next state
   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE, ST_DONE: begin
            if (acc_wr) begin
               state_next = ST_WRITE;
            end else if (acc_rd) begin
               state_next = ST_READ;
            end else begin
               state_next = ST_IDLE;
            end
         end
         ST_WRITE: begin
            // B arrives with the readies from this slave
            if (bvalid) begin
               state_next = ST_DONE;
            end
         end
         ST_READ: begin
            if (rvalid) begin
               state_next = ST_DONE;
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // request valids, each held until its own handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         arvalid <= 1'b0;
      end else begin
         if (acc_wr) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
         end else begin
            if (awvalid && awready) begin
               awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
               wvalid <= 1'b0;
            end
         end
         if (acc_rd) begin
            arvalid <= 1'b1;
         end else if (arvalid && arready) begin
            arvalid <= 1'b0;
         end
      end
   end

   // command latch
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= cmd;
      end
   end

   // capture B or R into the host response, writes return zero data
   always_ff @(posedge clk) begin
      if ((state == ST_WRITE) && bvalid) begin
         rsp <= '{op: OP_WRITE, resp: bresp, data: '0};
      end else if ((state == ST_READ) && rvalid) begin
         rsp <= '{op: OP_READ, resp: r.resp, data: r.data};
      end
   end

endmodule

// File: axil_mem_sys.f
axil_pkg.sv
axil_ram.sv
axil_cmd_fsm.sv
axil_txn_counter.sv
axil_mem_sys.sv
tb_axil_mem_sys.sv

// File: axil_mem_sys.sv
/* axil_mem_sys: host command FSM driving an AXI4-Lite RAM over an internal
   bus, with transaction counters and a direct debug port */
`timescale 1ns/1ps

module axil_mem_sys
   import axil_pkg::*;
#(
   parameter int MEM_WORDS_LOG2 = 10,
   parameter int CNT_W          = 16
) (
   input  logic                   clk,
   input  logic                   rst,

   // host command port
   input  logic                   cmd_valid,
   input  host_cmd_t              cmd,
   output logic                   busy,
   output logic                   rsp_valid,
   output host_rsp_t              rsp,

   // debug port straight to the RAM
   input  logic [AXIL_ADDR_W-1:0] dbg_rd_addr,
   output logic [AXIL_DATA_W-1:0] dbg_rd_data,
   input  logic [AXIL_ADDR_W-1:0] dbg_wr_addr,
   input  logic [AXIL_DATA_W-1:0] dbg_wr_data,
   input  logic                   dbg_wr_en,

   // counters
   output logic [CNT_W-1:0]       rd_count,
   output logic [CNT_W-1:0]       wr_count,
   output logic [CNT_W-1:0]       err_count
);

   // internal AXI4-Lite bus
   logic       awvalid;
   logic       awready;
   axil_aw_t   aw;
   logic       wvalid;
   logic       wready;
   axil_w_t    w;
   logic       bvalid;
   logic       bready;
   axil_resp_e bresp;
   logic       arvalid;
   logic       arready;
   axil_ar_t   ar;
   logic       rvalid;
   logic       rready;
   axil_r_t    r;

   logic       rsp_err;

   // anything but OKAY counts as an error
   assign rsp_err = (rsp.resp != RESP_OKAY);

   axil_cmd_fsm u_cmd_fsm (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .busy      (busy),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .awvalid   (awvalid),
      .awready   (awready),
      .aw        (aw),
      .wvalid    (wvalid),
      .wready    (wready),
      .w         (w),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .arvalid   (arvalid),
      .arready   (arready),
      .ar        (ar),
      .rvalid    (rvalid),
      .rready    (rready),
      .r         (r)
   );

   axil_ram #(
      .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
   ) u_ram (
      .clk         (clk),
      .rst         (rst),
      .dbg_rd_addr (dbg_rd_addr),
      .dbg_rd_data (dbg_rd_data),
      .dbg_wr_addr (dbg_wr_addr),
      .dbg_wr_data (dbg_wr_data),
      .dbg_wr_en   (dbg_wr_en),
      .awvalid     (awvalid),
      .awready     (awready),
      .aw          (aw),
      .wvalid      (wvalid),
      .wready      (wready),
      .w           (w),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .arvalid     (arvalid),
      .arready     (arready),
      .ar          (ar),
      .rvalid      (rvalid),
      .rready      (rready),
      .r           (r)
   );

   axil_txn_counter #(
      .CNT_W (CNT_W)
   ) u_txn_counter (
      .clk       (clk),
      .rst       (rst),
      .rsp_valid (rsp_valid),
      .op        (rsp.op),
      .err       (rsp_err),
      .rd_count  (rd_count),
      .wr_count  (wr_count),
      .err_count (err_count)
   );

endmodule

// File: axil_pkg.sv
/* axil_pkg: shared widths, AXI4-Lite channel structs, response codes
   and the opcode and state enums of the memory subsystem */
package axil_pkg;

   // bus geometry
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_ADDR_W = 16;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // host opcode, one bit
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } axil_op_e;

   // only the two codes this subsystem produces
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_e;

   // command FSM states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_WRITE = 2'd1,
      ST_READ  = 2'd2,
      ST_DONE  = 2'd3
   } cmd_state_e;

   // host side command and response
   typedef struct packed {
      axil_op_e               op;
      logic [AXIL_ADDR_W-1:0] addr;
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
   } host_cmd_t;

   typedef struct packed {
      axil_op_e               op;
      axil_resp_e             resp;
      logic [AXIL_DATA_W-1:0] data;
   } host_rsp_t;

   // AXI4-Lite payloads, valid/ready travel beside them
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
      logic [2:0]             prot;
   } axil_aw_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
      logic [2:0]             prot;
   } axil_ar_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      axil_resp_e             resp;
   } axil_r_t;

endpackage

// File: axil_ram.sv
/* axil_ram: AXI4-Lite slave RAM with byte strobes, SLVERR on out-of-range
   addresses and a word-wide debug port */
`timescale 1ns/1ps

module axil_ram
   import axil_pkg::*;
#(
   parameter int MEM_WORDS_LOG2 = 10
) (
   input  logic                   clk,
   input  logic                   rst,

   // debug port, word indices
   input  logic [AXIL_ADDR_W-1:0] dbg_rd_addr,
   output logic [AXIL_DATA_W-1:0] dbg_rd_data,
   input  logic [AXIL_ADDR_W-1:0] dbg_wr_addr,
   input  logic [AXIL_DATA_W-1:0] dbg_wr_data,
   input  logic                   dbg_wr_en,

   // write address / data / response
   input  logic                   awvalid,
   output logic                   awready,
   input  axil_aw_t               aw,
   input  logic                   wvalid,
   output logic                   wready,
   input  axil_w_t                w,
   output logic                   bvalid,
   input  logic                   bready,
   output axil_resp_e             bresp,

   // read address / data
   input  logic                   arvalid,
   output logic                   arready,
   input  axil_ar_t               ar,
   output logic                   rvalid,
   input  logic                   rready,
   output axil_r_t                r
);

   localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;
   // byte address minus the two byte-lane bits
   localparam int WORD_IDX_W = AXIL_ADDR_W - 2;

   logic [AXIL_DATA_W-1:0] mem [MEM_WORDS];

   logic [WORD_IDX_W-1:0] wr_idx;
   logic [WORD_IDX_W-1:0] rd_idx;
   logic                  wr_oor;
   logic                  rd_oor;
   logic                  wr_start;
   logic                  rd_start;
   logic                  mem_wr_en;
   logic                  dbg_wr_ok;

   // word index from byte address
   assign wr_idx = aw.addr[AXIL_ADDR_W-1:2];
   assign rd_idx = ar.addr[AXIL_ADDR_W-1:2];

   // anything above the array is out of range
   assign wr_oor = (wr_idx >> MEM_WORDS_LOG2) != '0;
   assign rd_oor = (rd_idx >> MEM_WORDS_LOG2) != '0;

   // take a write when both channels present, B free, and not mid-handshake
   assign wr_start = awvalid && wvalid && (!bvalid || bready) && !awready && !wready;
   // reads the same way against the R channel
   assign rd_start = arvalid && (!rvalid || rready) && !arready;

   // out-of-range writes are answered but never touch the array
   assign mem_wr_en = wr_start && !wr_oor;

   // bus write to the same word wins over the debug write
   assign dbg_wr_ok = dbg_wr_en &&
                      !(mem_wr_en && (dbg_wr_addr[MEM_WORDS_LOG2-1:0] ==
                                      wr_idx[MEM_WORDS_LOG2-1:0]));

   // combinational debug read, index wraps onto the array
   assign dbg_rd_data = mem[dbg_rd_addr[MEM_WORDS_LOG2-1:0]];

   // array writes
   always_ff @(posedge clk) begin
      if (dbg_wr_ok) begin
         mem[dbg_wr_addr[MEM_WORDS_LOG2-1:0]] <= dbg_wr_data;
      end
      if (mem_wr_en) begin
         // only strobed lanes
         for (int i = 0; i < AXIL_STRB_W; i++) begin
            if (w.strb[i]) begin
               mem[wr_idx[MEM_WORDS_LOG2-1:0]][8*i +: 8] <= w.data[8*i +: 8];
            end
         end
      end
   end

   // write handshake, readies pulse one cycle with bvalid
   always_ff @(posedge clk) begin
      if (rst) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         awready <= wr_start;
         wready  <= wr_start;
         if (wr_start) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // B payload
   always_ff @(posedge clk) begin
      if (wr_start) begin
         bresp <= wr_oor ? RESP_SLVERR : RESP_OKAY;
      end
   end

   // read handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= rd_start;
         if (rd_start) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // R payload, zero data on a miss
   always_ff @(posedge clk) begin
      if (rd_start) begin
         if (rd_oor) begin
            r.data <= '0;
            r.resp <= RESP_SLVERR;
         end else begin
            r.data <= mem[rd_idx[MEM_WORDS_LOG2-1:0]];
            r.resp <= RESP_OKAY;
         end
      end
   end

endmodule

// File: axil_txn_counter.sv
/* axil_txn_counter: saturating tallies of completed reads, writes
   and error responses */
`timescale 1ns/1ps

module axil_txn_counter
   import axil_pkg::*;
#(
   parameter int CNT_W = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             rsp_valid,
   input  axil_op_e         op,
   input  logic             err,
   output logic [CNT_W-1:0] rd_count,
   output logic [CNT_W-1:0] wr_count,
   output logic [CNT_W-1:0] err_count
);

   // stick at all ones
   function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
      return (&v) ? v : v + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_count  <= '0;
         wr_count  <= '0;
         err_count <= '0;
      end else if (rsp_valid) begin
         // one response per strobe
         if (op == OP_READ) begin
            rd_count <= sat_inc(rd_count);
         end else begin
            wr_count <= sat_inc(wr_count);
         end
         if (err) begin
            err_count <= sat_inc(err_count);
         end
      end
   end

endmodule

// File: tb_axil_mem_sys.sv
/* tb_axil_mem_sys: directed testbench for the AXI4-Lite memory subsystem,
   with a reference memory model, response timing checks and a watchdog */
`timescale 1ns/1ps

module tb_axil_mem_sys
   import axil_pkg::*;
;

   localparam int CLK_PERIOD     = 8;
   localparam int MEM_WORDS_LOG2 = 8;
   localparam int MEM_WORDS      = 1 << MEM_WORDS_LOG2;
   localparam int CNT_W          = 16;
   localparam int N_RAND         = 16;
   localparam int N_STRB         = 8;
   localparam int RSP_LIMIT      = 10;
   // bus commands issued over the whole run
   localparam int N_CMDS         = 2 * N_RAND + 2 * N_STRB + 4 + 2 + 3;
   localparam int WD_CYCLES      = N_CMDS * 10 + MEM_WORDS + 200;

   logic                   clk;
   logic                   rst;
   logic                   cmd_valid;
   host_cmd_t              cmd;
   logic                   busy;
   logic                   rsp_valid;
   host_rsp_t              rsp;
   logic [AXIL_ADDR_W-1:0] dbg_rd_addr;
   logic [AXIL_DATA_W-1:0] dbg_rd_data;
   logic [AXIL_ADDR_W-1:0] dbg_wr_addr;
   logic [AXIL_DATA_W-1:0] dbg_wr_data;
   logic                   dbg_wr_en;
   logic [CNT_W-1:0]       rd_count;
   logic [CNT_W-1:0]       wr_count;
   logic [CNT_W-1:0]       err_count;

   // reference model and tallies
   logic [AXIL_DATA_W-1:0] ref_mem [MEM_WORDS];
   int                     rd_tally;
   int                     wr_tally;
   int                     err_tally;
   string                  test_name;

   axil_mem_sys #(
      .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
      .CNT_W          (CNT_W)
   ) DUT (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .busy        (busy),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp),
      .dbg_rd_addr (dbg_rd_addr),
      .dbg_rd_data (dbg_rd_data),
      .dbg_wr_addr (dbg_wr_addr),
      .dbg_wr_data (dbg_wr_data),
      .dbg_wr_en   (dbg_wr_en),
      .rd_count    (rd_count),
      .wr_count    (wr_count),
      .err_count   (err_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // watchdog sized from the command count
   initial begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("run timed out after %0d cycles", WD_CYCLES);
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   task automatic check_val(input string what, input logic [63:0] exp,
                            input logic [63:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: %s expected %h actual %h",
                  test_name, what, exp, act);
         $display("test failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   // fill value, every index bit shows up
   function automatic logic [AXIL_DATA_W-1:0] fill_word(input int idx);
      return 32'hc3a5_0000 | (32'(idx) << 8) | (32'(idx) ^ 32'h3c);
   endfunction

   // keep old bytes where strobe is clear
   function automatic logic [AXIL_DATA_W-1:0] merge_bytes(
      input logic [AXIL_DATA_W-1:0] old_w,
      input logic [AXIL_DATA_W-1:0] new_w,
      input logic [AXIL_STRB_W-1:0] strb);
      logic [AXIL_DATA_W-1:0] res;
      res = old_w;
      for (int i = 0; i < AXIL_STRB_W; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return res;
   endfunction

   // one command, response expected exactly 3 cycles after the strobe
   task automatic issue_cmd(input axil_op_e op, input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data,
                            input logic [AXIL_STRB_W-1:0] strb,
                            output host_rsp_t rsp_out);
      int   lat;
      int   idx;
      logic oor;
      idx = int'(addr >> 2);
      oor = idx >= MEM_WORDS;
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd       <= '{op: op, addr: addr, data: data, strb: strb};
      @(posedge clk);
      cmd_valid <= 1'b0;
      @(negedge clk);
      lat = 1;
      check_val("busy after accept", 1, busy);
      while (!rsp_valid) begin
         if (lat >= RSP_LIMIT) begin
            $display("no response for command at address %h after %0d cycles",
                     addr, lat);
            $display("test failed");
            $fatal(1, "missing response");
         end
         @(negedge clk);
         lat++;
      end
      rsp_out = rsp;
      check_val("rsp latency", 3, lat);
      check_val("busy with rsp", 0, busy);
      check_val("rsp op", op, rsp.op);
      check_val("rsp resp", oor ? RESP_SLVERR : RESP_OKAY, rsp.resp);
      // model and tally
      if (op == OP_WRITE) begin
         wr_tally++;
         if (!oor) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
         end
      end else begin
         rd_tally++;
         check_val("rsp data", oor ? '0 : ref_mem[idx], rsp.data);
      end
      if (oor) begin
         err_tally++;
      end
   endtask

   task automatic fill_memory();
      for (int i = 0; i < MEM_WORDS; i++) begin
         @(posedge clk);
         dbg_wr_en   <= 1'b1;
         dbg_wr_addr <= AXIL_ADDR_W'(i);
         dbg_wr_data <= fill_word(i);
         ref_mem[i] = fill_word(i);
      end
      @(posedge clk);
      dbg_wr_en <= 1'b0;
   endtask

   task automatic test_reset_state();
      test_name = "reset_state";
      @(negedge clk);
      check_val("busy", 0, busy);
      check_val("rsp_valid", 0, rsp_valid);
      check_val("rd_count", 0, rd_count);
      check_val("wr_count", 0, wr_count);
      check_val("err_count", 0, err_count);
   endtask

   task automatic test_write_read();
      host_rsp_t              r_out;
      logic [AXIL_ADDR_W-1:0] a;
      logic [AXIL_DATA_W-1:0] d;
      test_name = "write_read";
      for (int i = 0; i < N_RAND; i++) begin
         a = AXIL_ADDR_W'(($urandom % MEM_WORDS) << 2);
         d = $urandom;
         issue_cmd(OP_WRITE, a, d, 4'hf, r_out);
         issue_cmd(OP_READ, a, '0, '0, r_out);
         check_val("read back", d, r_out.data);
      end
   endtask

   task automatic test_byte_strobes();
      host_rsp_t              r_out;
      logic [AXIL_STRB_W-1:0] pat [N_STRB];
      logic [AXIL_ADDR_W-1:0] a;
      logic [AXIL_DATA_W-1:0] d;
      logic [AXIL_DATA_W-1:0] exp_w;
      test_name = "byte_strobes";
      pat = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101, 4'b1010};
      for (int i = 0; i < N_STRB; i++) begin
         a = AXIL_ADDR_W'((8'h80 + i) << 2);
         d = $urandom;
         // unstrobed lanes of d must not reach the array
         exp_w = merge_bytes(ref_mem[8'h80 + i], d, pat[i]);
         issue_cmd(OP_WRITE, a, d, pat[i], r_out);
         issue_cmd(OP_READ, a, '0, '0, r_out);
         check_val("merged word", exp_w, r_out.data);
      end
   endtask

   task automatic test_out_of_range();
      host_rsp_t              r_out;
      logic [AXIL_ADDR_W-1:0] oor_addr [2];
      int                     wrap;
      test_name = "out_of_range";
      oor_addr = '{16'h0404, 16'hfffc};
      foreach (oor_addr[k]) begin
         wrap = int'(oor_addr[k] >> 2) % MEM_WORDS;
         issue_cmd(OP_WRITE, oor_addr[k], $urandom, 4'hf, r_out);
         check_val("write resp", RESP_SLVERR, r_out.resp);
         // wrapped word must be untouched
         @(posedge clk);
         dbg_rd_addr <= AXIL_ADDR_W'(wrap);
         @(negedge clk);
         check_val("wrapped word", ref_mem[wrap], dbg_rd_data);
         issue_cmd(OP_READ, oor_addr[k], '0, '0, r_out);
         check_val("read resp", RESP_SLVERR, r_out.resp);
         check_val("read data", 0, r_out.data);
      end
   endtask

   task automatic test_debug_port();
      host_rsp_t              r_out;
      logic [AXIL_DATA_W-1:0] d;
      test_name = "debug_port";
      // debug write then bus read
      d = $urandom;
      @(posedge clk);
      dbg_wr_en   <= 1'b1;
      dbg_wr_addr <= 16'h0021;
      dbg_wr_data <= d;
      ref_mem[8'h21] = d;
      @(posedge clk);
      dbg_wr_en <= 1'b0;
      issue_cmd(OP_READ, 16'h0021 << 2, '0, '0, r_out);
      check_val("bus sees debug write", d, r_out.data);
      // bus write then debug read
      d = $urandom;
      issue_cmd(OP_WRITE, 16'h0042 << 2, d, 4'hf, r_out);
      @(posedge clk);
      dbg_rd_addr <= 16'h0042;
      @(negedge clk);
      check_val("debug sees bus write", d, dbg_rd_data);
   endtask

   task automatic test_busy_counters();
      host_rsp_t              r_out;
      logic [AXIL_DATA_W-1:0] d1;
      int                     pulses;
      int                     at;
      test_name = "busy_counters";
      d1 = $urandom;
      pulses = 0;
      at = 0;
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd       <= '{op: OP_WRITE, addr: 16'h0050 << 2, data: d1, strb: 4'hf};
      @(posedge clk);
      // second strobe lands while busy
      cmd <= '{op: OP_WRITE, addr: 16'h0051 << 2, data: ~d1, strb: 4'hf};
      @(negedge clk);
      check_val("busy during txn", 1, busy);
      check_val("no early rsp", 0, rsp_valid);
      @(posedge clk);
      cmd_valid <= 1'b0;
      for (int k = 2; k < 10; k++) begin
         @(negedge clk);
         if (rsp_valid) begin
            pulses++;
            at = k;
         end
      end
      check_val("rsp pulses", 1, pulses);
      check_val("rsp cycle", 3, at);
      ref_mem[8'h50] = d1;
      wr_tally++;
      // ignored write left its word alone
      issue_cmd(OP_READ, 16'h0051 << 2, '0, '0, r_out);
      issue_cmd(OP_READ, 16'h0050 << 2, '0, '0, r_out);
      check_val("accepted write", d1, r_out.data);
      // counters one cycle after the last response
      @(negedge clk);
      check_val("rd_count", rd_tally, rd_count);
      check_val("wr_count", wr_tally, wr_count);
      check_val("err_count", err_tally, err_count);
   endtask

   initial begin
      int seed_ret;
      seed_ret    = $urandom(32'h2e7c_3e96);
      rd_tally    = 0;
      wr_tally    = 0;
      err_tally   = 0;
      test_name   = "init";
      rst         = 1'b1;
      cmd_valid   = 1'b0;
      cmd         = '0;
      dbg_rd_addr = '0;
      dbg_wr_addr = '0;
      dbg_wr_data = '0;
      dbg_wr_en   = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      test_reset_state();
      fill_memory();
      test_write_read();
      test_byte_strobes();
      test_out_of_range();
      test_debug_port();
      test_busy_counters();
      $display("test passed");
      $finish;
   end

endmodule
